//--- source/pipe_config.svh
// Data width, register address width and data RAM address width
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// ==============================
// Datapath sizes
// ==============================

// Integer register and data word width
`define PIPE_XLEN 32

// Register address width, 32 registers
`define PIPE_REG_AW 5

// ==============================
// Data memory
// ==============================

// Word address width, 64 words
`define PIPE_RAM_AW 6

`endif

//--- source/pipe_pkg.sv
// Operation codes and write-back source types of the pipeline
`default_nettype none

package pipe_pkg;

  // ==============================
  // Operations
  // ==============================

  typedef enum logic [3:0] {
    OP_NOP = 4'd0,   // Bubble
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_SLT = 4'd6,   // Signed compare
    OP_SLL = 4'd7,
    OP_SRL = 4'd8,
    OP_LW  = 4'd9,   // rs1 + imm
    OP_SW  = 4'd10   // rs1 + imm, data from rs2
  } op_e;

  // ==============================
  // Write-back source
  // ==============================

  // Selects what goes into the register file
  typedef enum logic [1:0] {
    WB_NONE = 2'd0,  // No register write
    WB_EXE  = 2'd1,  // ALU result
    WB_MEM  = 2'd2   // Load data
  } wb_src_e;

endpackage

`default_nettype wire

//--- source/reg_file.sv
// Register file with two read ports, one write port and write-first bypass
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module reg_file (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [`PIPE_REG_AW-1:0]  rs1_addr,
  input  wire [`PIPE_REG_AW-1:0]  rs2_addr,
  input  wire                     wr_ena,
  input  wire [`PIPE_REG_AW-1:0]  wr_addr,
  input  wire [`PIPE_XLEN-1:0]    wr_data,
  output logic [`PIPE_XLEN-1:0]   rs1_now,
  output logic [`PIPE_XLEN-1:0]   rs2_now
);

  localparam int NREG = 1 << `PIPE_REG_AW;

  logic [`PIPE_XLEN-1:0] regs [0:NREG-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;          // x0 never written
    end
  end

  // New data wins over the stored word
  function automatic logic [`PIPE_XLEN-1:0] read_port(input logic [`PIPE_REG_AW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_ena && (addr == wr_addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_now = read_port(rs1_addr);
    rs2_now = read_port(rs2_addr);
  end

endmodule

`default_nettype wire

//--- source/operand_forward.sv
// Operand forwarding selection for both execute stage operands
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module operand_forward (
  input  wire [`PIPE_REG_AW-1:0]  rs1_addr,
  input  wire [`PIPE_REG_AW-1:0]  rs2_addr,
  input  wire [`PIPE_REG_AW-1:0]  mem_reg_wr_addr,
  input  wire                     mem_reg_wr_ena,
  input  wire pipe_pkg::wb_src_e  mem_wb_src,
  input  wire [`PIPE_REG_AW-1:0]  wb_reg_wr_addr,
  input  wire                     wb_reg_wr_ena,
  input  wire pipe_pkg::wb_src_e  wb_wb_src,
  input  wire [`PIPE_XLEN-1:0]    mem_ex_data,
  input  wire [`PIPE_XLEN-1:0]    wb_ex_data,
  input  wire [`PIPE_XLEN-1:0]    wb_mem_data,
  input  wire [`PIPE_XLEN-1:0]    rs1_now,
  input  wire [`PIPE_XLEN-1:0]    rs2_now,
  output logic [`PIPE_XLEN-1:0]   rs1_forward,
  output logic [`PIPE_XLEN-1:0]   rs2_forward
);

  // A stage supplies the operand only for the right kind of write
  function automatic logic hit(input logic [`PIPE_REG_AW-1:0] addr,
                               input logic [`PIPE_REG_AW-1:0] dst,
                               input logic                    ena,
                               input pipe_pkg::wb_src_e       src,
                               input pipe_pkg::wb_src_e       kind);
    return (addr == dst) && ena && (addr != '0) && (src == kind);
  endfunction

  function automatic logic [`PIPE_XLEN-1:0] pick(input logic [`PIPE_REG_AW-1:0] addr,
                                                 input logic [`PIPE_XLEN-1:0]   now);
    if (hit(addr, mem_reg_wr_addr, mem_reg_wr_ena, mem_wb_src, pipe_pkg::WB_EXE)) begin
      return mem_ex_data;                // Youngest first
    end
    if (hit(addr, wb_reg_wr_addr, wb_reg_wr_ena, wb_wb_src, pipe_pkg::WB_EXE)) begin
      return wb_ex_data;
    end
    if (hit(addr, wb_reg_wr_addr, wb_reg_wr_ena, wb_wb_src, pipe_pkg::WB_MEM)) begin
      return wb_mem_data;
    end
    return now;
  endfunction

  // ==============================
  // Operand select
  // ==============================

  always_comb begin
    rs1_forward = pick(rs1_addr, rs1_now);
    rs2_forward = pick(rs2_addr, rs2_now);
  end

endmodule

`default_nettype wire

//--- source/exec_stage.sv
// Execute stage operand registers, ALU and execute to memory result registers
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module exec_stage (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     issue_accept,
  input  wire pipe_pkg::op_e      issue_op,
  input  wire [`PIPE_XLEN-1:0]    issue_imm,
  input  wire                     issue_use_imm,
  input  wire [`PIPE_XLEN-1:0]    rs1_now,
  input  wire [`PIPE_XLEN-1:0]    rs2_now,
  input  wire [`PIPE_REG_AW-1:0]  ex_rs1,
  input  wire [`PIPE_REG_AW-1:0]  ex_rs2,
  input  wire [`PIPE_REG_AW-1:0]  mem_rd,
  input  wire                     mem_wr_ena,
  input  wire pipe_pkg::wb_src_e  mem_wb_src,
  input  wire [`PIPE_REG_AW-1:0]  wb_rd_q,
  input  wire                     wb_wr_ena,
  input  wire pipe_pkg::wb_src_e  wb_wb_src,
  input  wire [`PIPE_XLEN-1:0]    wb_ex_data,
  input  wire [`PIPE_XLEN-1:0]    wb_mem_data,
  output logic [`PIPE_XLEN-1:0]   mem_ex_data,
  output logic [`PIPE_XLEN-1:0]   mem_store_data
);

  pipe_pkg::op_e          op_q;
  logic                   use_imm_q;
  logic [`PIPE_XLEN-1:0]  imm_q;
  logic [`PIPE_XLEN-1:0]  rs1_q;
  logic [`PIPE_XLEN-1:0]  rs2_q;
  logic [`PIPE_XLEN-1:0]  rs1_fwd;
  logic [`PIPE_XLEN-1:0]  rs2_fwd;
  logic [`PIPE_XLEN-1:0]  op2;
  logic [`PIPE_XLEN-1:0]  alu_res;

  // ==============================
  // Issue to execute registers
  // ==============================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q      <= pipe_pkg::OP_NOP;
      use_imm_q <= 1'b0;
    end else if (issue_accept) begin
      op_q      <= issue_op;
      use_imm_q <= issue_use_imm;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_accept) begin
      imm_q <= issue_imm;
      rs1_q <= rs1_now;                  // Already bypassed
      rs2_q <= rs2_now;
    end
  end

  operand_forward u_fwd (
    .rs1_addr        (ex_rs1),
    .rs2_addr        (ex_rs2),
    .mem_reg_wr_addr (mem_rd),
    .mem_reg_wr_ena  (mem_wr_ena),
    .mem_wb_src      (mem_wb_src),
    .wb_reg_wr_addr  (wb_rd_q),
    .wb_reg_wr_ena   (wb_wr_ena),
    .wb_wb_src       (wb_wb_src),
    .mem_ex_data     (mem_ex_data),
    .wb_ex_data      (wb_ex_data),
    .wb_mem_data     (wb_mem_data),
    .rs1_now         (rs1_q),
    .rs2_now         (rs2_q),
    .rs1_forward     (rs1_fwd),
    .rs2_forward     (rs2_fwd)
  );

  // ==============================
  // ALU
  // ==============================

  assign op2 = use_imm_q ? imm_q : rs2_fwd;

  always_comb begin
    case (op_q)
      pipe_pkg::OP_ADD: alu_res = rs1_fwd + op2;
      pipe_pkg::OP_SUB: alu_res = rs1_fwd - op2;
      pipe_pkg::OP_AND: alu_res = rs1_fwd & op2;
      pipe_pkg::OP_OR:  alu_res = rs1_fwd | op2;
      pipe_pkg::OP_XOR: alu_res = rs1_fwd ^ op2;
      pipe_pkg::OP_SLT: alu_res = {31'd0, $signed(rs1_fwd) < $signed(op2)};
      pipe_pkg::OP_SLL: alu_res = rs1_fwd << op2[4:0];
      pipe_pkg::OP_SRL: alu_res = rs1_fwd >> op2[4:0];
      pipe_pkg::OP_LW,
      pipe_pkg::OP_SW:  alu_res = rs1_fwd + imm_q;  // Address
      default:          alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    mem_ex_data    <= alu_res;
    mem_store_data <= rs2_fwd;
  end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
// Data RAM, memory to write-back registers and write-back data select
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module mem_stage (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [`PIPE_XLEN-1:0]    mem_ex_data,
  input  wire [`PIPE_XLEN-1:0]    mem_store_data,
  input  wire                     mem_store,
  input  wire                     mem_load,
  input  wire pipe_pkg::wb_src_e  wb_wb_src,
  output logic [`PIPE_XLEN-1:0]   wb_ex_data,
  output logic [`PIPE_XLEN-1:0]   wb_mem_data,
  output logic [`PIPE_XLEN-1:0]   wb_data
);

  localparam int DEPTH = 1 << `PIPE_RAM_AW;

  logic [`PIPE_XLEN-1:0]   ram [0:DEPTH-1];
  logic [`PIPE_RAM_AW-1:0] ram_addr;

  assign ram_addr = mem_ex_data[`PIPE_RAM_AW-1:0];  // Word address

  // ==============================
  // Data RAM
  // ==============================

  always_ff @(posedge clk) begin
    if (mem_store) begin
      ram[ram_addr] <= mem_store_data;
    end
    if (mem_load) begin
      wb_mem_data <= ram[ram_addr];      // Valid in write-back
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ex_data <= '0;
    end else begin
      wb_ex_data <= mem_ex_data;
    end
  end

  // Load data or ALU result into the register file
  assign wb_data = (wb_wb_src == pipe_pkg::WB_MEM) ? wb_mem_data : wb_ex_data;

endmodule

`default_nettype wire

//--- source/pipe_ctrl.sv
// Stage valid and destination tracking, load-use stall and bubble insertion
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module pipe_ctrl (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     issue_valid,
  input  wire pipe_pkg::op_e      issue_op,
  input  wire [`PIPE_REG_AW-1:0]  issue_rd,
  input  wire [`PIPE_REG_AW-1:0]  issue_rs1,
  input  wire [`PIPE_REG_AW-1:0]  issue_rs2,
  input  wire                     issue_use_imm,
  output logic                    stall,
  output logic                    issue_accept,
  output logic                    ex_valid,
  output pipe_pkg::op_e           ex_op,
  output logic [`PIPE_REG_AW-1:0] ex_rs1,
  output logic [`PIPE_REG_AW-1:0] ex_rs2,
  output logic [`PIPE_REG_AW-1:0] mem_rd,
  output logic                    mem_wr_ena,
  output pipe_pkg::wb_src_e       mem_wb_src,
  output logic                    mem_load,
  output logic                    mem_store,
  output logic [`PIPE_REG_AW-1:0] wb_rd_q,
  output logic                    wb_wr_ena,
  output pipe_pkg::wb_src_e       wb_wb_src,
  output logic                    wb_valid,
  output logic                    wb_we
);

  pipe_pkg::wb_src_e       issue_wb_src;
  logic                    issue_wr_ena;
  logic                    rs2_used;
  logic [`PIPE_REG_AW-1:0] ex_rd;
  logic                    ex_wr_ena;
  pipe_pkg::wb_src_e       ex_wb_src;
  logic                    mem_valid;

  always_comb begin
    case (issue_op)
      pipe_pkg::OP_LW:  issue_wb_src = pipe_pkg::WB_MEM;
      pipe_pkg::OP_SW,
      pipe_pkg::OP_NOP: issue_wb_src = pipe_pkg::WB_NONE;
      default:          issue_wb_src = pipe_pkg::WB_EXE;
    endcase
  end

  assign issue_wr_ena = (issue_wb_src != pipe_pkg::WB_NONE) && (issue_rd != '0);
  assign rs2_used     = !issue_use_imm || (issue_op == pipe_pkg::OP_SW);

  // ==============================
  // Load-use stall
  // ==============================

  assign stall = issue_valid && ex_valid && (ex_wb_src == pipe_pkg::WB_MEM) &&
                 (ex_rd != '0) &&
                 ((ex_rd == issue_rs1) || (rs2_used && (ex_rd == issue_rs2)));
  assign issue_accept = issue_valid && !stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid   <= 1'b0;
      ex_op      <= pipe_pkg::OP_NOP;
      ex_rd      <= '0;
      ex_rs1     <= '0;
      ex_rs2     <= '0;
      ex_wr_ena  <= 1'b0;
      ex_wb_src  <= pipe_pkg::WB_NONE;
      mem_valid  <= 1'b0;
      mem_rd     <= '0;
      mem_wr_ena <= 1'b0;
      mem_wb_src <= pipe_pkg::WB_NONE;
      mem_store  <= 1'b0;
      wb_valid   <= 1'b0;
      wb_rd_q    <= '0;
      wb_wr_ena  <= 1'b0;
      wb_wb_src  <= pipe_pkg::WB_NONE;
    end else begin
      ex_valid   <= issue_accept;        // Low on stall, bubble
      ex_op      <= issue_accept ? issue_op : pipe_pkg::OP_NOP;
      ex_rd      <= issue_rd;
      ex_rs1     <= issue_rs1;
      ex_rs2     <= issue_rs2;
      ex_wr_ena  <= issue_accept && issue_wr_ena;
      ex_wb_src  <= issue_accept ? issue_wb_src : pipe_pkg::WB_NONE;
      mem_valid  <= ex_valid;
      mem_rd     <= ex_rd;
      mem_wr_ena <= ex_wr_ena;
      mem_wb_src <= ex_wb_src;
      mem_store  <= ex_valid && (ex_op == pipe_pkg::OP_SW);
      wb_valid   <= mem_valid;
      wb_rd_q    <= mem_rd;
      wb_wr_ena  <= mem_wr_ena;
      wb_wb_src  <= mem_wb_src;
    end
  end

  assign mem_load = (mem_wb_src == pipe_pkg::WB_MEM);
  assign wb_we    = wb_valid && wb_wr_ena;

endmodule

`default_nettype wire

//--- source/exec_pipe_top.sv
// Pipeline back end top joining control, register file and datapath stages
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module exec_pipe_top (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      issue_valid,
  input  wire pipe_pkg::op_e       issue_op,
  input  wire [`PIPE_REG_AW-1:0]   issue_rd,
  input  wire [`PIPE_REG_AW-1:0]   issue_rs1,
  input  wire [`PIPE_REG_AW-1:0]   issue_rs2,
  input  wire [`PIPE_XLEN-1:0]     issue_imm,
  input  wire                      issue_use_imm,
  output wire                      stall,
  output wire                      wb_valid,
  output wire [`PIPE_REG_AW-1:0]   wb_rd,
  output wire [`PIPE_XLEN-1:0]     wb_data,
  output wire                      wb_we
);

  wire                     issue_accept;
  wire [`PIPE_XLEN-1:0]    rs1_now;
  wire [`PIPE_XLEN-1:0]    rs2_now;
  wire [`PIPE_REG_AW-1:0]  ex_rs1;
  wire [`PIPE_REG_AW-1:0]  ex_rs2;
  wire [`PIPE_REG_AW-1:0]  mem_rd;
  wire                     mem_wr_ena;
  wire pipe_pkg::wb_src_e  mem_wb_src;
  wire                     mem_load;
  wire                     mem_store;
  wire                     wb_wr_ena;
  wire pipe_pkg::wb_src_e  wb_wb_src;
  wire [`PIPE_XLEN-1:0]    mem_ex_data;
  wire [`PIPE_XLEN-1:0]    mem_store_data;
  wire [`PIPE_XLEN-1:0]    wb_ex_data;
  wire [`PIPE_XLEN-1:0]    wb_mem_data;

  pipe_ctrl u_ctrl (
    .clk (clk), .arst_n (arst_n),
    .issue_valid (issue_valid), .issue_op (issue_op), .issue_rd (issue_rd),
    .issue_rs1 (issue_rs1), .issue_rs2 (issue_rs2), .issue_use_imm (issue_use_imm),
    .stall (stall), .issue_accept (issue_accept),
    .ex_valid (), .ex_op (), .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2),
    .mem_rd (mem_rd), .mem_wr_ena (mem_wr_ena), .mem_wb_src (mem_wb_src),
    .mem_load (mem_load), .mem_store (mem_store),
    .wb_rd_q (wb_rd), .wb_wr_ena (wb_wr_ena), .wb_wb_src (wb_wb_src),
    .wb_valid (wb_valid), .wb_we (wb_we)
  );

  reg_file u_rf (
    .clk (clk), .arst_n (arst_n),
    .rs1_addr (issue_rs1), .rs2_addr (issue_rs2),
    .wr_ena (wb_we), .wr_addr (wb_rd), .wr_data (wb_data),
    .rs1_now (rs1_now), .rs2_now (rs2_now)
  );

  exec_stage u_exe (
    .clk (clk), .arst_n (arst_n), .issue_accept (issue_accept),
    .issue_op (issue_op), .issue_imm (issue_imm), .issue_use_imm (issue_use_imm),
    .rs1_now (rs1_now), .rs2_now (rs2_now), .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2),
    .mem_rd (mem_rd), .mem_wr_ena (mem_wr_ena), .mem_wb_src (mem_wb_src),
    .wb_rd_q (wb_rd), .wb_wr_ena (wb_wr_ena), .wb_wb_src (wb_wb_src),
    .wb_ex_data (wb_ex_data), .wb_mem_data (wb_mem_data),
    .mem_ex_data (mem_ex_data), .mem_store_data (mem_store_data)
  );

  mem_stage u_mem (
    .clk (clk), .arst_n (arst_n),
    .mem_ex_data (mem_ex_data), .mem_store_data (mem_store_data),
    .mem_store (mem_store), .mem_load (mem_load), .wb_wb_src (wb_wb_src),
    .wb_ex_data (wb_ex_data), .wb_mem_data (wb_mem_data), .wb_data (wb_data)
  );

endmodule

`default_nettype wire

//--- tb/tb_exec_pipe.sv
// Testbench with golden vector issue, write-back scoreboard, stall check and timeout
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module tb_exec_pipe;

  localparam int MAX_VEC = 64;
  localparam int COLS    = 8;        // Words per vector line

  logic                     clk;
  logic                     arst_n;
  logic                     issue_valid;
  pipe_pkg::op_e            issue_op;
  logic [`PIPE_REG_AW-1:0]  issue_rd;
  logic [`PIPE_REG_AW-1:0]  issue_rs1;
  logic [`PIPE_REG_AW-1:0]  issue_rs2;
  logic [`PIPE_XLEN-1:0]    issue_imm;
  logic                     issue_use_imm;
  wire                      stall;
  wire                      wb_valid;
  wire [`PIPE_REG_AW-1:0]   wb_rd;
  wire [`PIPE_XLEN-1:0]     wb_data;
  wire                      wb_we;

  logic [31:0]              vec_mem [0:COLS*MAX_VEC];  // Word 0 is the count
  int                       n_vec;
  int                       errors;
  int                       retired;
  int                       cycles;
  int                       cycle_limit;
  int                       seed;
  logic                     prev_load;
  logic [`PIPE_REG_AW-1:0]  prev_rd;

  // Expected write-backs, oldest first
  logic [`PIPE_REG_AW-1:0]  exp_rd_q [$];
  logic                     exp_we_q [$];
  logic [`PIPE_XLEN-1:0]    exp_data_q [$];

  exec_pipe_top dut (
    .clk (clk), .arst_n (arst_n),
    .issue_valid (issue_valid), .issue_op (issue_op), .issue_rd (issue_rd),
    .issue_rs1 (issue_rs1), .issue_rs2 (issue_rs2),
    .issue_imm (issue_imm), .issue_use_imm (issue_use_imm),
    .stall (stall), .wb_valid (wb_valid), .wb_rd (wb_rd),
    .wb_data (wb_data), .wb_we (wb_we)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // ==============================
  // Write-back scoreboard
  // ==============================

  task automatic check_retire();
    logic [`PIPE_REG_AW-1:0] exp_rd;
    logic                    exp_we;
    logic [`PIPE_XLEN-1:0]   exp_data;
    if (exp_rd_q.size() == 0) begin
      errors++;
      $display("Write-back at %0d ns with no instruction outstanding", $time);
    end else begin
      exp_rd   = exp_rd_q.pop_front();
      exp_we   = exp_we_q.pop_front();
      exp_data = exp_data_q.pop_front();
      check_value("wb_rd", 32'(wb_rd), 32'(exp_rd));
      check_value("wb_we", 32'(wb_we), 32'(exp_we));
      if (exp_we) begin
        check_value("wb_data", wb_data, exp_data);   // Only register writes carry a value
      end
      retired++;
    end
  endtask

  always @(negedge clk) begin
    if (arst_n && wb_valid) begin
      check_retire();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Run timed out after %0d cycles with %0d write-backs still missing",
               cycle_limit, exp_rd_q.size());
      $display("Errors: %0d, retired %0d of %0d", errors, retired, n_vec);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ==============================
  // Issue
  // ==============================

  // Called just after a rising edge, returns just after the accepting edge
  task automatic issue_vector(input int idx);
    int                       base;
    int                       gap;
    int                       stall_cycles;
    logic                     rs2_used;
    logic                     exp_stall;
    pipe_pkg::op_e            op;
    logic [`PIPE_REG_AW-1:0]  rd;
    logic [`PIPE_REG_AW-1:0]  rs1;
    logic [`PIPE_REG_AW-1:0]  rs2;
    logic                     use_imm;
    base    = 1 + idx * COLS;
    op      = pipe_pkg::op_e'(vec_mem[base][3:0]);
    rd      = vec_mem[base+1][`PIPE_REG_AW-1:0];
    rs1     = vec_mem[base+2][`PIPE_REG_AW-1:0];
    rs2     = vec_mem[base+3][`PIPE_REG_AW-1:0];
    use_imm = vec_mem[base+5][0];
    gap     = int'(($random(seed) & 32'h7fff_ffff) % 3);
    if (prev_load) begin
      gap = 0;                         // Next one right behind the load
    end
    if (gap > 0) begin
      issue_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    issue_valid   <= 1'b1;
    issue_op      <= op;
    issue_rd      <= rd;
    issue_rs1     <= rs1;
    issue_rs2     <= rs2;
    issue_imm     <= vec_mem[base+4];
    issue_use_imm <= use_imm;
    // Hazard only when the load is in execute right now
    rs2_used  = !use_imm || (op == pipe_pkg::OP_SW);
    exp_stall = prev_load && (prev_rd != '0) && (gap == 0) &&
                ((rs1 == prev_rd) || (rs2_used && (rs2 == prev_rd)));
    stall_cycles = 0;
    @(negedge clk);
    while (stall) begin
      stall_cycles++;
      @(negedge clk);
    end
    check_value("stall cycles", stall_cycles, 32'(exp_stall));
    @(posedge clk);                    // Accepted here
    exp_rd_q.push_back(rd);
    exp_we_q.push_back(vec_mem[base+6][0]);
    exp_data_q.push_back(vec_mem[base+7]);
    prev_load = (op == pipe_pkg::OP_LW);
    prev_rd   = rd;
  endtask

  initial begin
    seed          = 32'hc46d;
    errors        = 0;
    retired       = 0;
    cycles        = 0;
    prev_load     = 1'b0;
    prev_rd       = '0;
    arst_n        = 1'b0;
    issue_valid   = 1'b0;
    issue_op      = pipe_pkg::OP_NOP;
    issue_rd      = '0;
    issue_rs1     = '0;
    issue_rs2     = '0;
    issue_imm     = '0;
    issue_use_imm = 1'b0;
    $readmemh("tb/golden_pipe_vectors.txt", vec_mem);
    n_vec = int'(vec_mem[0]);
    if (n_vec < 1 || n_vec > MAX_VEC) begin
      errors++;
      $display("Vector file gives an unusable vector count of %0d", n_vec);
      n_vec = 0;
    end
    cycle_limit = 6 * n_vec + 50;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < n_vec; i++) begin
      issue_vector(i);
    end
    issue_valid <= 1'b0;
    while (exp_rd_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);         // Room for a duplicate retire
    $display("Errors: %0d, retired %0d of %0d", errors, retired, n_vec);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/golden_pipe_vectors.txt
// First word is the vector count. Then per line, in hex:
// op rd rs1 rs2 imm use_imm exp_we exp_data (exp_data is checked only when exp_we is 1)
19
1 01 00 00 00000010 1 1 00000010
1 02 00 00 fffffff0 1 1 fffffff0
1 03 00 00 00000005 1 1 00000005
2 04 01 03 00000000 0 1 0000000b
3 05 02 00 000000ff 1 1 000000f0
4 06 01 03 00000000 0 1 00000015
5 07 02 00 ffffffff 1 1 0000000f
6 08 02 01 00000000 0 1 00000001
6 09 01 02 00000000 0 1 00000000
7 0a 03 00 00000004 1 1 00000050
8 0b 02 00 00000004 1 1 0fffffff
1 0c 01 01 00000000 0 1 00000020
1 0c 0c 01 00000000 0 1 00000030
1 0c 0c 0c 00000000 0 1 00000060
a 00 00 0c 00000008 1 0 00000000
a 00 01 04 00000004 1 0 00000000
9 0d 00 00 00000008 1 1 00000060
1 0e 0d 03 00000000 0 1 00000065
9 0f 01 00 00000004 1 1 0000000b
a 00 00 0f 00000020 1 0 00000000
9 10 00 00 00000020 1 1 0000000b
1 00 01 03 00000000 0 0 00000000
4 11 00 03 00000000 0 1 00000005
2 12 11 10 00000000 0 1 fffffffa
5 13 12 12 00000000 0 1 00000000

//--- flist.f
+incdir+source
source/pipe_pkg.sv
source/reg_file.sv
source/operand_forward.sv
source/exec_stage.sv
source/mem_stage.sv
source/pipe_ctrl.sv
source/exec_pipe_top.sv
tb/tb_exec_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build the pipeline testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
  --top-module tb_exec_pipe -Mdir obj_dir -o sim_exec_pipe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_exec_pipe)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
